// File: common/lsu_pkg.sv
////////////////////////////////////////////////////////////
// Shared types for the load/store unit
// Address, data, byte-enable and offset vectors
// Access size codes and default outstanding depth
////////////////////////////////////////////////////////////

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Byte address as seen by the pipeline and the bus
  typedef logic [31:0] addr_t;

  // One data word, bus side or register side
  typedef logic [31:0] data_t;

  // One enable per byte lane of a data word
  typedef logic [3:0] be_t;

  // Byte position inside a word
  typedef logic [1:0] offset_t;

  // Access size code
  typedef logic [1:0] lsu_size_t;

  ////////////////////////////////////////////////////////////
  // Size codes
  ////////////////////////////////////////////////////////////

  // Byte access
  localparam lsu_size_t SIZE_BYTE = 2'd0;

  // Halfword access
  localparam lsu_size_t SIZE_HALF = 2'd1;

  // Word access, code 3 is handled the same way
  localparam lsu_size_t SIZE_WORD = 2'd2;

  ////////////////////////////////////////////////////////////
  // Defaults
  ////////////////////////////////////////////////////////////

  // Max bus transactions in flight
  localparam int LSU_DEPTH_DEFAULT = 2;

endpackage

// File: hw/lsu_req/lsu_req_gen.sv
////////////////////////////////////////////////////////////
// Request generation for the load/store unit
// Address sum, byte enables, write-data rotation and
// tracking of the second phase of a split access
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_req_gen import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_0_i,
  input  addr_t     op_a_i,
  input  addr_t     op_b_i,
  input  data_t     wdata_i,
  input  lsu_size_t size_i,
  input  logic      accept_i,
  output addr_t     addr_o,
  output be_t       be_o,
  output data_t     wdata_o,
  output logic      split_o,
  output offset_t   offset_o
);

  // Raw access address
  addr_t   addr;
  // Low address bits
  offset_t offset;
  // Second address phase of a split access in progress
  logic    split_q;

  assign addr   = op_a_i + op_b_i;
  assign offset = addr[1:0];

  // Context side always wants the original offset
  assign offset_o = offset;

  ////////////////////////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////////////////////////

  // Word not on a word boundary, or halfword crossing into next word
  // Only flagged in the first phase
  always_comb begin
    split_o = 1'b0;
    if (valid_0_i && !split_q) begin
      case (size_i)
        SIZE_BYTE: split_o = 1'b0;
        SIZE_HALF: split_o = (offset == 2'd3);
        default:   split_o = (offset != 2'd0);
      endcase
    end
  end

  // Set on the accepted first phase, cleared on the second
  // Dropped access must not leave it set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;
    end else if (accept_i) begin
      split_q <= split_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address
  ////////////////////////////////////////////////////////////

  // Second phase goes to the next aligned word
  assign addr_o = split_q ? ({addr[31:2], 2'b00} + 32'd4) : addr;

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    be_o = 4'b0000;
    case (size_i)
      SIZE_BYTE: begin
        // Single lane picked by the offset
        be_o = 4'b0001 << offset;
      end
      SIZE_HALF: begin
        if (split_q) begin
          // Upper byte lands in lane 0 of the next word
          be_o = 4'b0001;
        end else begin
          case (offset)
            2'd0:    be_o = 4'b0011;
            2'd1:    be_o = 4'b0110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
      end
      default: begin
        if (split_q) begin
          // Remaining low lanes of the next word
          case (offset)
            2'd1:    be_o = 4'b0001;
            2'd2:    be_o = 4'b0011;
            2'd3:    be_o = 4'b0111;
            default: be_o = 4'b0000;
          endcase
        end else begin
          // Lanes from the offset up to the top of the word
          case (offset)
            2'd0:    be_o = 4'b1111;
            2'd1:    be_o = 4'b1110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Write data
  ////////////////////////////////////////////////////////////

  // Rotate left by offset bytes
  // Same rotation serves both phases, the enables pick the lanes
  always_comb begin
    case (offset)
      2'd0:    wdata_o = wdata_i;
      2'd1:    wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0], wdata_i[31:8]};
    endcase
  end

endmodule

// File: hw/lsu_req/lsu_txn_ctrl.sv
////////////////////////////////////////////////////////////
// Transaction control for the load/store unit
// Outstanding counter, bus request gating,
// pipeline ready and busy indication
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_txn_ctrl import lsu_pkg::*; #(
  parameter int DEPTH = LSU_DEPTH_DEFAULT
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,
  input  logic split_i,
  input  logic gnt_i,
  input  logic rvalid_i,
  output logic req_o,
  output logic accept_o,
  output logic ready_0_o,
  output logic busy_o
);

  // Counter must be able to hold DEPTH itself
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  // Transactions granted but not yet answered
  cnt_t cnt_q;
  cnt_t cnt_d;
  // Room for one more transaction
  logic slot_free;
  logic count_up;
  logic count_down;

  ////////////////////////////////////////////////////////////
  // Request and accept
  ////////////////////////////////////////////////////////////

  // Only registered count matters here
  // a response in this cycle frees its slot next cycle
  assign slot_free = (cnt_q < cnt_t'(DEPTH));

  // Request follows the pipeline valid directly
  assign req_o = valid_0_i && slot_free;

  // OBI address phase completes on req and gnt together
  assign accept_o = req_o && gnt_i;

  // EX may move on once the last phase is accepted
  // First half of a split keeps it waiting
  assign ready_0_o = accept_o && !split_i;

  // Anything in flight or being requested
  assign busy_o = (cnt_q != '0) || req_o;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  assign count_up   = accept_o;
  assign count_down = rvalid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10: begin
        // New grant only
        cnt_d = cnt_q + cnt_t'(1);
      end
      2'b01: begin
        // Response only
        cnt_d = cnt_q - cnt_t'(1);
      end
      default: begin
        // Idle, or grant and response cancel out
        cnt_d = cnt_q;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: hw/lsu_resp/lsu_rdata_align.sv
////////////////////////////////////////////////////////////
// Read-data path of the load/store unit
// Response context queue, split holding register,
// realignment and zero or sign extension
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_rdata_align import lsu_pkg::*; #(
  parameter int DEPTH = LSU_DEPTH_DEFAULT
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      accept_i,
  input  logic      split_i,
  input  logic      we_i,
  input  logic      sext_i,
  input  lsu_size_t size_i,
  input  offset_t   offset_i,
  input  logic      rvalid_i,
  input  data_t     rdata_i,
  output logic      valid_1_o,
  output logic      last_1_o,
  output data_t     rdata_1_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Context queue, one entry per granted transaction
  lsu_size_t        ctx_size_q   [DEPTH];
  logic             ctx_sext_q   [DEPTH];
  offset_t          ctx_offset_q [DEPTH];
  logic             ctx_we_q     [DEPTH];
  logic             ctx_last_q   [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;

  // Head entry, belongs to the response on the bus
  lsu_size_t head_size;
  logic      head_sext;
  offset_t   head_offset;
  logic      head_we;
  logic      head_last;

  // First-half data of a split load
  data_t       rdata_q;
  logic        is_split;
  logic [63:0] rdata_full;
  logic [63:0] rdata_shift;

  ////////////////////////////////////////////////////////////
  // Context queue
  ////////////////////////////////////////////////////////////

  // Push on grant; last is clear for the first half of a split
  always_ff @(posedge clk) begin
    if (accept_i) begin
      ctx_size_q[wr_ptr_q]   <= size_i;
      ctx_sext_q[wr_ptr_q]   <= sext_i;
      ctx_offset_q[wr_ptr_q] <= offset_i;
      ctx_we_q[wr_ptr_q]     <= we_i;
      ctx_last_q[wr_ptr_q]   <= !split_i;
    end
  end

  // Pointers wrap at DEPTH, occupancy is bounded by the counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (accept_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  assign head_size   = ctx_size_q[rd_ptr_q];
  assign head_sext   = ctx_sext_q[rd_ptr_q];
  assign head_offset = ctx_offset_q[rd_ptr_q];
  assign head_we     = ctx_we_q[rd_ptr_q];
  assign head_last   = ctx_last_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////
  // Split holding register
  ////////////////////////////////////////////////////////////

  // Keep the low word of a split load until its second half arrives
  always_ff @(posedge clk) begin
    if (rvalid_i && !head_we && !head_last) begin
      rdata_q <= rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Realignment and extension
  ////////////////////////////////////////////////////////////

  // Same split rule as on the request side
  assign is_split = ((head_size == SIZE_HALF) && (head_offset == 2'd3)) ||
                    ((head_size != SIZE_BYTE) && (head_size != SIZE_HALF) &&
                     (head_offset != 2'd0));

  // Non-split data is doubled so the shift wraps it around
  assign rdata_full  = is_split ? {rdata_i, rdata_q} : {rdata_i, rdata_i};
  assign rdata_shift = rdata_full >> {head_offset, 3'b000};

  always_comb begin
    case (head_size)
      SIZE_BYTE: rdata_1_o = {{24{head_sext && rdata_shift[7]}}, rdata_shift[7:0]};
      SIZE_HALF: rdata_1_o = {{16{head_sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:   rdata_1_o = rdata_shift[31:0];
    endcase
  end

  // Every response is passed on, last marks completion
  assign valid_1_o = rvalid_i;
  assign last_1_o  = rvalid_i && head_last;

endmodule

// File: hw/lsu_top.sv
////////////////////////////////////////////////////////////
// Load/store unit top level
// Request generation, transaction control and read-data
// realignment joined between the pipeline and the OBI bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; #(
  parameter int DEPTH = LSU_DEPTH_DEFAULT
) (
  input  logic      clk,
  input  logic      rst_n,

  // EX side
  input  logic      valid_0_i,
  input  addr_t     op_a_i,
  input  addr_t     op_b_i,
  input  data_t     wdata_i,
  input  logic      we_i,
  input  logic      sext_i,
  input  lsu_size_t size_i,
  output logic      ready_0_o,
  output logic      busy_o,

  // WB side
  output logic      valid_1_o,
  output logic      last_1_o,
  output data_t     rdata_1_o,

  // OBI data bus
  output logic      req_o,
  input  logic      gnt_i,
  output logic      we_o,
  output addr_t     addr_o,
  output be_t       be_o,
  output data_t     wdata_o,
  input  logic      rvalid_i,
  input  data_t     rdata_i
);

  // Address phase accepted by the bus
  logic    accept;
  // Current phase is the first half of a split access
  logic    split;
  // Byte offset of the access address
  offset_t offset;

  // Write enable needs no per-phase change
  assign we_o = we_i;

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  lsu_req_gen u_req_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_0_i (valid_0_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .wdata_i   (wdata_i),
    .size_i    (size_i),
    .accept_i  (accept),
    .addr_o    (addr_o),
    .be_o      (be_o),
    .wdata_o   (wdata_o),
    .split_o   (split),
    .offset_o  (offset)
  );

  ////////////////////////////////////////////////////////////
  // Outstanding count and handshakes
  ////////////////////////////////////////////////////////////

  lsu_txn_ctrl #(
    .DEPTH (DEPTH)
  ) u_txn_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_0_i (valid_0_i),
    .split_i   (split),
    .gnt_i     (gnt_i),
    .rvalid_i  (rvalid_i),
    .req_o     (req_o),
    .accept_o  (accept),
    .ready_0_o (ready_0_o),
    .busy_o    (busy_o)
  );

  ////////////////////////////////////////////////////////////
  // Read-data path
  ////////////////////////////////////////////////////////////

  lsu_rdata_align #(
    .DEPTH (DEPTH)
  ) u_rdata_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept_i  (accept),
    .split_i   (split),
    .we_i      (we_i),
    .sext_i    (sext_i),
    .size_i    (size_i),
    .offset_i  (offset),
    .rvalid_i  (rvalid_i),
    .rdata_i   (rdata_i),
    .valid_1_o (valid_1_o),
    .last_1_o  (last_1_o),
    .rdata_1_o (rdata_1_o)
  );

endmodule

// File: sim/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock source
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic clk_o
);

  // Free running, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// File: sim/lsu_sva.sv
////////////////////////////////////////////////////////////
// Bus and outstanding-count assertions for the LSU
// Bound into the top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_sva import lsu_pkg::*; #(
  parameter int DEPTH = LSU_DEPTH_DEFAULT
) (
  input logic  clk,
  input logic  rst_n,
  input logic  req_o,
  input logic  gnt_i,
  input logic  we_o,
  input addr_t addr_o,
  input be_t   be_o,
  input data_t wdata_o,
  input logic  rvalid_i
);

  // Granted transactions still waiting for a response
  int outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + ((req_o && gnt_i) ? 1 : 0) - (rvalid_i ? 1 : 0);
    end
  end

  // OBI address phase must hold until granted
  a_req_held : assert property (@(posedge clk) disable iff (!rst_n)
    (req_o && !gnt_i) |=> (req_o && $stable(addr_o) && $stable(be_o) &&
                           $stable(wdata_o) && $stable(we_o)))
    else $error("Request dropped or changed before grant");

  a_rvalid_owed : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (outstanding > 0))
    else $error("Response with no transaction outstanding");

  a_depth_limit : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= DEPTH)
    else $error("More transactions outstanding than DEPTH");

endmodule

bind lsu_top lsu_sva #(
  .DEPTH (DEPTH)
) u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .req_o    (req_o),
  .gnt_i    (gnt_i),
  .we_o     (we_o),
  .addr_o   (addr_o),
  .be_o     (be_o),
  .wdata_o  (wdata_o),
  .rvalid_i (rvalid_i)
);

// File: sim/lsu_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the load/store unit
// Stimulus, OBI memory model with random delays,
// shadow-memory reference and in-order result checker
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*; ();

  localparam int DEPTH   = LSU_DEPTH_DEFAULT;
  localparam int TIMEOUT = 100;

  logic      clk;
  logic      rst_n;
  logic      valid_0_i;
  addr_t     op_a_i;
  addr_t     op_b_i;
  data_t     wdata_i;
  logic      we_i;
  logic      sext_i;
  lsu_size_t size_i;
  logic      ready_0_o;
  logic      busy_o;
  logic      valid_1_o;
  logic      last_1_o;
  data_t     rdata_1_o;
  logic      req_o;
  logic      gnt_i;
  logic      we_o;
  addr_t     addr_o;
  be_t       be_o;
  data_t     wdata_o;
  logic      rvalid_i;
  data_t     rdata_i;

  // Bus-side memory and the shadow the reference reads
  logic [7:0]  bus_mem    [256];
  logic [7:0]  shadow_mem [256];
  logic [31:0] rng_state;

  // Memory model state
  int          cyc;
  int          gnt_wait;
  logic        hold_resp;
  data_t       rsp_data_q [$];
  int          rsp_rdy_q  [$];
  int          bus_base;
  // Own generator state, bus delays stay apart from stimulus draws
  logic [31:0] bus_rnd;

  // Expected responses, one last flag per bus response
  logic  exp_last_q [$];
  data_t exp_val_q  [$];
  logic  exp_load_q [$];
  string exp_name_q [$];
  logic  cmp_last;
  data_t cmp_val;
  logic  cmp_load;
  string cmp_name;

  // Access currently presented to the DUT
  addr_t cur_addr;
  int    cur_phases;
  string cur_name;

  int          mismatch_cnt;
  int          error_cnt;
  logic [31:0] stim_r;
  logic [31:0] stim_d;
  addr_t       stim_a;
  lsu_size_t   stim_s;

  tb_clk_gen #(.PERIOD(20)) u_clk_gen (.clk_o(clk));

  lsu_top #(
    .DEPTH (DEPTH)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_0_i (valid_0_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .wdata_i   (wdata_i),
    .we_i      (we_i),
    .sext_i    (sext_i),
    .size_i    (size_i),
    .ready_0_o (ready_0_o),
    .busy_o    (busy_o),
    .valid_1_o (valid_1_o),
    .last_1_o  (last_1_o),
    .rdata_1_o (rdata_1_o),
    .req_o     (req_o),
    .gnt_i     (gnt_i),
    .we_o      (we_o),
    .addr_o    (addr_o),
    .be_o      (be_o),
    .wdata_o   (wdata_o),
    .rvalid_i  (rvalid_i),
    .rdata_i   (rdata_i)
  );

  ////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic roll(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  function automatic int size_bytes(input lsu_size_t s);
    case (s)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  // Bus transactions an access needs
  function automatic int phases_for(input addr_t a, input lsu_size_t s);
    if (s == SIZE_BYTE) return 1;
    if (s == SIZE_HALF) return (a[1:0] == 2'd3) ? 2 : 1;
    return (a[1:0] != 2'd0) ? 2 : 1;
  endfunction

  // Memory is 256 bytes, addresses wrap
  function automatic int byte_idx(input addr_t a, input int i);
    return int'((a + addr_t'(i)) & 32'hFF);
  endfunction

  // Little-endian gather from the shadow, then extension
  function automatic data_t load_ref(input addr_t a, input lsu_size_t s, input logic sx);
    data_t v;
    int    n;
    n = size_bytes(s);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = shadow_mem[byte_idx(a, i)];
    end
    if (sx && n < 4 && v[8*n-1]) begin
      for (int j = n; j < 4; j++) begin
        v[8*j +: 8] = 8'hFF;
      end
    end
    return v;
  endfunction

  task automatic report_mismatch(input string name, input data_t exp, input data_t act);
    $display("Mismatch %s: expected %08h actual %08h", name, exp, act);
    mismatch_cnt++;
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Mismatches: %0d, other errors: %0d", mismatch_cnt, error_cnt);
    $display("ERRORS FOUND");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Access sequencing
  ////////////////////////////////////////////////////////////

  // Present one access, operands split at random so the adder is exercised
  task automatic start_access(input addr_t a, input logic w, input lsu_size_t s,
                              input logic sx, input data_t d, input string name);
    logic [31:0] r;
    roll(r);
    @(negedge clk);
    op_b_i     = {26'd0, r[5:0]};
    op_a_i     = a - {26'd0, r[5:0]};
    we_i       = w;
    size_i     = s;
    sext_i     = sx;
    wdata_i    = d;
    valid_0_i  = 1'b1;
    cur_addr   = a;
    cur_phases = phases_for(a, s);
    cur_name   = name;
    if (w) begin
      for (int i = 0; i < size_bytes(s); i++) begin
        shadow_mem[byte_idx(a, i)] = d[8*i +: 8];
      end
    end
    if (cur_phases == 2) begin
      exp_last_q.push_back(1'b0);
    end
    exp_last_q.push_back(1'b1);
    exp_val_q.push_back(w ? '0 : load_ref(a, s, sx));
    exp_load_q.push_back(!w);
    exp_name_q.push_back(name);
  endtask

  // Count granted phases until ready, checking each phase address
  task automatic finish_access();
    int    n;
    int    t;
    logic  done;
    addr_t exp_addr;
    n    = 0;
    t    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (req_o && gnt_i) begin
        exp_addr = (n == 0) ? cur_addr : ((cur_addr & ~32'd3) + 32'd4);
        assert (addr_o == exp_addr)
          else report_mismatch({cur_name, " addr_o"}, exp_addr, addr_o);
        n++;
      end
      if (ready_0_o) begin
        assert (n == cur_phases) else begin
          error_cnt++;
          $display("%s: ready_0_o after %0d of %0d phases", cur_name, n, cur_phases);
        end
        done = 1'b1;
      end
      t++;
      if (!done && t > TIMEOUT) abort_run({"Timeout waiting for ready_0_o in ", cur_name});
    end
  endtask

  // Idle the pipeline and wait for every response
  task automatic drain();
    int t;
    t = 0;
    @(negedge clk);
    valid_0_i = 1'b0;
    @(negedge clk);
    while (rsp_rdy_q.size() != 0) begin
      assert (busy_o) else begin
        error_cnt++;
        $display("busy_o low while responses are pending");
      end
      @(negedge clk);
      t++;
      if (t > TIMEOUT) abort_run("Timeout waiting for outstanding responses");
    end
    assert (!busy_o && exp_last_q.size() == 0) else begin
      error_cnt++;
      $display("Unit still busy or responses missing after drain");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // OBI memory model
  ////////////////////////////////////////////////////////////

  // Sample on the rising edge: writes, response queue, grant delay
  always @(posedge clk) begin
    if (rst_n) begin
      cyc++;
      if (rvalid_i) begin
        void'(rsp_data_q.pop_front());
        void'(rsp_rdy_q.pop_front());
      end
      if (req_o && gnt_i) begin
        bus_base = {24'd0, addr_o[7:2], 2'b00};
        if (we_o) begin
          for (int j = 0; j < 4; j++) begin
            if (be_o[j]) bus_mem[bus_base + j] = wdata_o[8*j +: 8];
          end
        end
        // Read data captured at grant time
        rsp_data_q.push_back({bus_mem[bus_base + 3], bus_mem[bus_base + 2],
                              bus_mem[bus_base + 1], bus_mem[bus_base]});
        bus_rnd = xorshift32(bus_rnd);
        rsp_rdy_q.push_back(cyc + int'(bus_rnd % 32'd3));
        bus_rnd = xorshift32(bus_rnd);
        gnt_wait = int'(bus_rnd % 32'd3);
      end else if (req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
    end
  end

  // Drive grant and in-order responses on the falling edge
  always @(negedge clk) begin
    gnt_i = (gnt_wait == 0);
    if (rsp_rdy_q.size() != 0 && cyc >= rsp_rdy_q[0] && !hold_resp) begin
      rvalid_i = 1'b1;
      rdata_i  = rsp_data_q[0];
    end else begin
      rvalid_i = 1'b0;
      rdata_i  = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Result checker
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n && valid_1_o) begin
      assert (exp_last_q.size() != 0) else begin
        error_cnt++;
        $display("Response on valid_1_o with no access outstanding");
      end
      if (exp_last_q.size() != 0) begin
        cmp_last = exp_last_q.pop_front();
        assert (last_1_o == cmp_last)
          else report_mismatch({exp_name_q[0], " last_1_o"}, {31'd0, cmp_last},
                               {31'd0, last_1_o});
        if (cmp_last) begin
          cmp_val  = exp_val_q.pop_front();
          cmp_load = exp_load_q.pop_front();
          cmp_name = exp_name_q.pop_front();
          if (cmp_load) begin
            assert (rdata_1_o == cmp_val)
              else report_mismatch({cmp_name, " rdata_1_o"}, cmp_val, rdata_1_o);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    valid_0_i    = 1'b0;
    op_a_i       = '0;
    op_b_i       = '0;
    wdata_i      = '0;
    we_i         = 1'b0;
    sext_i       = 1'b0;
    size_i       = SIZE_BYTE;
    gnt_i        = 1'b0;
    rvalid_i     = 1'b0;
    rdata_i      = '0;
    rng_state    = 32'd92;
    bus_rnd      = 32'd92;
    cyc          = 0;
    gnt_wait     = 0;
    hold_resp    = 1'b0;
    mismatch_cnt = 0;
    error_cnt    = 0;
    for (int i = 0; i < 256; i++) begin
      bus_mem[i]    = 8'((i * 37) ^ 8'h5A);
      shadow_mem[i] = 8'((i * 37) ^ 8'h5A);
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Quiet outputs until the first access
    repeat (4) begin
      @(posedge clk);
      assert (!req_o && !valid_1_o && !busy_o) else begin
        error_cnt++;
        $display("Outputs active after reset with no access presented");
      end
    end

    // Aligned stores, each read back zero- and sign-extended
    for (int i = 0; i < 12; i++) begin
      roll(stim_r);
      roll(stim_d);
      stim_s = lsu_size_t'(i % 3);
      stim_a = {24'd0, stim_r[7:0]};
      if (stim_s == SIZE_HALF) stim_a[0] = 1'b0;
      if (stim_s == SIZE_WORD) stim_a[1:0] = 2'b00;
      start_access(stim_a, 1'b1, stim_s, 1'b0, stim_d, "aligned store");
      finish_access();
      start_access(stim_a, 1'b0, stim_s, 1'b0, '0, "aligned load zext");
      finish_access();
      start_access(stim_a, 1'b0, stim_s, 1'b1, '0, "aligned load sext");
      finish_access();
    end

    // Split accesses, words at offsets 1 to 3 and halfwords at offset 3
    for (int i = 0; i < 8; i++) begin
      roll(stim_r);
      roll(stim_d);
      stim_s = ((i % 4) == 3) ? SIZE_HALF : SIZE_WORD;
      stim_a = {24'd0, stim_r[7:2], (stim_s == SIZE_HALF) ? 2'd3 : 2'((i % 4) + 1)};
      start_access(stim_a, 1'b1, stim_s, 1'b0, stim_d, "split store");
      finish_access();
      start_access(stim_a, 1'b0, stim_s, stim_r[8], '0, "split load");
      finish_access();
    end

    // Random mix back to back
    for (int i = 0; i < 40; i++) begin
      roll(stim_r);
      roll(stim_d);
      start_access({24'd0, stim_r[7:0]}, stim_r[8], stim_r[10:9], stim_r[11], stim_d,
                   "random");
      finish_access();
    end
    drain();

    // Responses withheld, next request must wait for a free slot
    @(posedge clk);
    hold_resp = 1'b1;
    for (int i = 0; i < DEPTH; i++) begin
      start_access(32'h40 + addr_t'(4 * i), 1'b0, SIZE_WORD, 1'b0, '0, "outstanding limit");
      finish_access();
    end
    start_access(32'h80, 1'b0, SIZE_WORD, 1'b0, '0, "outstanding limit");
    repeat (6) begin
      @(posedge clk);
      assert (!req_o && busy_o) else begin
        error_cnt++;
        $display("Request raised or unit idle with %0d transactions outstanding", DEPTH);
      end
    end
    hold_resp = 1'b0;
    finish_access();
    drain();

    // Byte enables and write rotation leave the bus memory equal to the shadow
    for (int i = 0; i < 256; i++) begin
      assert (bus_mem[i] == shadow_mem[i])
        else report_mismatch($sformatf("memory byte %0d", i), {24'd0, shadow_mem[i]},
                             {24'd0, bus_mem[i]});
    end

    $display("Mismatches: %0d, other errors: %0d", mismatch_cnt, error_cnt);
    if (mismatch_cnt == 0 && error_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: sources.f
common/lsu_pkg.sv
hw/lsu_req/lsu_req_gen.sv
hw/lsu_req/lsu_txn_ctrl.sv
hw/lsu_resp/lsu_rdata_align.sv
hw/lsu_top.sv
sim/tb_clk_gen.sv
sim/lsu_sva.sv
sim/lsu_tb.sv

// File: Makefile
# Verilator simulation of the load/store unit

LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module lsu_tb -Mdir obj_dir
	./obj_dir/Vlsu_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
